/* rtl/nts_dispatcher_pkg.sv */
`default_nettype none

package nts_dispatcher_pkg;

  //--------------------------------------------------------------------------
  // Receive beat widths
  //--------------------------------------------------------------------------

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = 8;

  typedef logic [DATA_WIDTH-1:0] data_word_t;
  typedef logic [KEEP_WIDTH-1:0] keep_t;

  // Statistics and register bus
  typedef logic [63:0] counter_t;
  typedef logic [11:0] api_addr_t;
  typedef logic [31:0] api_word_t;

  //--------------------------------------------------------------------------
  // Bank life cycle
  //--------------------------------------------------------------------------

  typedef enum logic [2:0] {
    BANK_EMPTY     = 3'd0,
    BANK_RECEIVING = 3'd1,
    BANK_RECEIVED  = 3'd2,
    BANK_OFFERED   = 3'd3,
    BANK_READING   = 3'd4,
    BANK_DRAINED   = 3'd5
  } bank_state_e;

  //--------------------------------------------------------------------------
  // Counter register map, MSB read latches the LSB snapshot
  //--------------------------------------------------------------------------

  localparam api_addr_t ADDR_FRAMES_MSB     = 12'h010;
  localparam api_addr_t ADDR_FRAMES_LSB     = 12'h011;
  localparam api_addr_t ADDR_GOOD_MSB       = 12'h012;
  localparam api_addr_t ADDR_GOOD_LSB       = 12'h013;
  localparam api_addr_t ADDR_BAD_MSB        = 12'h014;
  localparam api_addr_t ADDR_BAD_LSB        = 12'h015;
  localparam api_addr_t ADDR_DISPATCHED_MSB = 12'h016;
  localparam api_addr_t ADDR_DISPATCHED_LSB = 12'h017;

endpackage

`default_nettype wire

/* rtl/bank_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface bank_if #(
  parameter int ADDR_WIDTH = 8
);

  // Arbiter to bank
  logic                            rx_select;
  logic                            read_start;
  logic                            discard;

  // Bank to arbiter
  nts_dispatcher_pkg::bank_state_e state;
  logic [ADDR_WIDTH-1:0]           word_count;
  nts_dispatcher_pkg::keep_t       last_keep;
  nts_dispatcher_pkg::data_word_t  rd_data;
  logic                            rd_valid;

  modport arbiter (
    output rx_select, read_start, discard,
    input  state, word_count, last_keep, rd_data, rd_valid
  );

  modport bank (
    input  rx_select, read_start, discard,
    output state, word_count, last_keep, rd_data, rd_valid
  );

endinterface

`default_nettype wire

/* rtl/frame_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_bank #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire nts_dispatcher_pkg::data_word_t i_rx_data,
  input  wire nts_dispatcher_pkg::keep_t i_rx_keep,
  input  wire                            i_rx_good,
  input  wire                            i_rx_bad,
  input  wire                            i_sof,
  bank_if.bank                           bank
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  nts_dispatcher_pkg::data_word_t  mem [DEPTH];

  nts_dispatcher_pkg::bank_state_e state;
  logic [ADDR_WIDTH-1:0]           word_count;
  logic [ADDR_WIDTH-1:0]           rd_addr;
  logic [ADDR_WIDTH-1:0]           wr_addr;
  logic [ADDR_WIDTH-1:0]           ram_addr;
  logic                            wr_en;
  logic                            beat_valid;
  logic                            bank_full;

  //--------------------------------------------------------------------------
  // Write side
  //--------------------------------------------------------------------------

  assign beat_valid = (i_rx_keep != '0);
  assign bank_full  = (word_count == {ADDR_WIDTH{1'b1}});

  // First beat lands at word 0, later beats append until the bank is full
  always_comb begin
    wr_en   = 1'b0;
    wr_addr = '0;
    if (bank.rx_select && beat_valid && !i_rx_bad) begin
      if (state == nts_dispatcher_pkg::BANK_EMPTY) begin
        wr_en = 1'b1;
      end else if (state == nts_dispatcher_pkg::BANK_RECEIVING && !bank_full) begin
        wr_en   = 1'b1;
        wr_addr = word_count + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Single port RAM, write has priority over read
  //--------------------------------------------------------------------------

  assign ram_addr = wr_en ? wr_addr : rd_addr;

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem[ram_addr] <= i_rx_data;
    end
    bank.rd_data <= mem[ram_addr];
  end

  //--------------------------------------------------------------------------
  // Bank state machine
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state          <= nts_dispatcher_pkg::BANK_EMPTY;
      word_count     <= '0;
      rd_addr        <= '0;
      bank.last_keep <= '0;
      bank.rd_valid  <= 1'b0;
    end else begin
      // RAM data follows the read address by one cycle
      bank.rd_valid <= (state == nts_dispatcher_pkg::BANK_READING);

      if (wr_en) begin
        word_count <= wr_addr;
      end

      if (bank.discard) begin
        state <= nts_dispatcher_pkg::BANK_EMPTY;
      end else if (bank.rx_select) begin
        if (i_rx_bad) begin
          state <= nts_dispatcher_pkg::BANK_EMPTY;
        end else begin
          case (state)
            nts_dispatcher_pkg::BANK_EMPTY: begin
              if (i_sof) begin
                state <= nts_dispatcher_pkg::BANK_RECEIVING;
              end
            end
            nts_dispatcher_pkg::BANK_RECEIVING: begin
              if (i_rx_good) begin
                bank.last_keep <= i_rx_keep;
                state          <= nts_dispatcher_pkg::BANK_RECEIVED;
              end
            end
            default: ;
          endcase
        end
      end else begin
        case (state)
          // Deselected after a swap, so the frame is now on offer
          nts_dispatcher_pkg::BANK_RECEIVED: begin
            state <= nts_dispatcher_pkg::BANK_OFFERED;
          end
          nts_dispatcher_pkg::BANK_OFFERED: begin
            if (bank.read_start) begin
              rd_addr <= '0;
              state   <= nts_dispatcher_pkg::BANK_READING;
            end
          end
          nts_dispatcher_pkg::BANK_READING: begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == word_count) begin
              state <= nts_dispatcher_pkg::BANK_DRAINED;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign bank.state      = state;
  assign bank.word_count = word_count;

  // Receive never targets a bank in read-out, so the RAM port stays free
  a_no_write_while_reading: assert property (
    @(posedge i_clk) disable iff (i_areset)
    (state == nts_dispatcher_pkg::BANK_READING) |-> !bank.rx_select
  );

endmodule

`default_nettype wire

/* rtl/bank_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                            i_clk,
  input  wire                            i_areset,
  bank_if.arbiter                        bank0,
  bank_if.arbiter                        bank1,
  output logic                           o_dispatch_packet_available,
  output logic [ADDR_WIDTH-1:0]          o_dispatch_counter,
  output nts_dispatcher_pkg::keep_t      o_dispatch_data_valid,
  output logic                           o_dispatch_fifo_empty,
  input  wire                            i_dispatch_fifo_rd_start,
  output logic                           o_dispatch_fifo_rd_valid,
  output nts_dispatcher_pkg::data_word_t o_dispatch_fifo_rd_data,
  input  wire                            i_dispatch_packet_read_discard,
  output logic                           o_dispatch_start
);

  // Low while bank0 receives and bank1 is read out
  logic                            cur_bank;

  nts_dispatcher_pkg::bank_state_e rx_state;
  nts_dispatcher_pkg::bank_state_e rd_state;
  logic                            rd_bank_valid;
  logic                            swap;
  logic                            rd_busy;

  assign rx_state      = cur_bank ? bank1.state : bank0.state;
  assign rd_state      = cur_bank ? bank0.state : bank1.state;
  assign rd_bank_valid = cur_bank ? bank0.rd_valid : bank1.rd_valid;

  assign swap = (rx_state == nts_dispatcher_pkg::BANK_RECEIVED) &&
                (rd_state == nts_dispatcher_pkg::BANK_EMPTY);

  //--------------------------------------------------------------------------
  // Control routing
  //--------------------------------------------------------------------------

  assign bank0.rx_select  = !cur_bank;
  assign bank1.rx_select  = cur_bank;
  assign bank0.read_start = cur_bank & i_dispatch_fifo_rd_start;
  assign bank1.read_start = !cur_bank & i_dispatch_fifo_rd_start;
  assign bank0.discard    = cur_bank & i_dispatch_packet_read_discard;
  assign bank1.discard    = !cur_bank & i_dispatch_packet_read_discard;

  // Offer view of the read bank
  assign o_dispatch_packet_available = (rd_state == nts_dispatcher_pkg::BANK_OFFERED);
  assign o_dispatch_counter    = cur_bank ? bank0.word_count : bank1.word_count;
  assign o_dispatch_data_valid = cur_bank ? bank0.last_keep : bank1.last_keep;
  assign o_dispatch_start      = i_dispatch_fifo_rd_start && o_dispatch_packet_available;

  // A freshly swapped bank is still RECEIVED for one cycle before the offer
  assign rd_busy = (rd_state == nts_dispatcher_pkg::BANK_RECEIVED) ||
                   (rd_state == nts_dispatcher_pkg::BANK_OFFERED) ||
                   (rd_state == nts_dispatcher_pkg::BANK_READING) ||
                   rd_bank_valid;

  //--------------------------------------------------------------------------
  // Bank swap and output stage
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      cur_bank                 <= 1'b0;
      o_dispatch_fifo_rd_valid <= 1'b0;
      o_dispatch_fifo_empty    <= 1'b1;
    end else begin
      if (swap) begin
        cur_bank <= !cur_bank;
      end
      o_dispatch_fifo_rd_valid <= rd_bank_valid;
      o_dispatch_fifo_empty    <= i_dispatch_packet_read_discard || !rd_busy;
    end
  end

  always_ff @(posedge i_clk) begin
    o_dispatch_fifo_rd_data <= cur_bank ? bank0.rd_data : bank1.rd_data;
  end

  // Only the read bank can stream
  a_single_reader: assert property (
    @(posedge i_clk) disable iff (i_areset)
    !((bank0.state == nts_dispatcher_pkg::BANK_READING) &&
      (bank1.state == nts_dispatcher_pkg::BANK_READING))
  );

endmodule

`default_nettype wire

/* rtl/rx_stats.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_stats (
  input  wire                              i_clk,
  input  wire                              i_areset,
  input  wire nts_dispatcher_pkg::keep_t   i_rx_keep,
  input  wire                              i_rx_good,
  input  wire                              i_rx_bad,
  input  wire                              i_dispatch_start,
  output logic                             o_sof,
  input  wire                              i_api_cs,
  input  wire                              i_api_we,
  input  wire nts_dispatcher_pkg::api_addr_t i_api_address,
  output nts_dispatcher_pkg::api_word_t    o_api_read_data
);

  // Counter order follows the register map
  localparam int NUM_COUNTERS = 4;

  nts_dispatcher_pkg::keep_t     prev_keep;
  nts_dispatcher_pkg::counter_t  cnt  [NUM_COUNTERS];
  nts_dispatcher_pkg::api_word_t snap [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0]       evt;
  logic [NUM_COUNTERS-1:0]       snap_we;

  //--------------------------------------------------------------------------
  // Start of frame, idle beat followed by a full beat
  //--------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      prev_keep <= '1;
    end else begin
      prev_keep <= i_rx_keep;
    end
  end

  assign o_sof = (prev_keep == '0) && (i_rx_keep == '1);

  //--------------------------------------------------------------------------
  // Counters and LSB snapshots
  //--------------------------------------------------------------------------

  assign evt = {i_dispatch_start, i_rx_bad, i_rx_good, o_sof};

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        cnt[i]  <= '0;
        snap[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (evt[i]) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
        if (snap_we[i]) begin
          snap[i] <= cnt[i][31:0];
        end
      end
    end
  end

  // Register read, writes have no target
  always_comb begin
    o_api_read_data = '0;
    snap_we         = '0;
    if (i_api_cs && !i_api_we) begin
      case (i_api_address)
        nts_dispatcher_pkg::ADDR_FRAMES_MSB: begin
          o_api_read_data = cnt[0][63:32];
          snap_we[0]      = 1'b1;
        end
        nts_dispatcher_pkg::ADDR_FRAMES_LSB:     o_api_read_data = snap[0];
        nts_dispatcher_pkg::ADDR_GOOD_MSB: begin
          o_api_read_data = cnt[1][63:32];
          snap_we[1]      = 1'b1;
        end
        nts_dispatcher_pkg::ADDR_GOOD_LSB:       o_api_read_data = snap[1];
        nts_dispatcher_pkg::ADDR_BAD_MSB: begin
          o_api_read_data = cnt[2][63:32];
          snap_we[2]      = 1'b1;
        end
        nts_dispatcher_pkg::ADDR_BAD_LSB:        o_api_read_data = snap[2];
        nts_dispatcher_pkg::ADDR_DISPATCHED_MSB: begin
          o_api_read_data = cnt[3][63:32];
          snap_we[3]      = 1'b1;
        end
        nts_dispatcher_pkg::ADDR_DISPATCHED_LSB: o_api_read_data = snap[3];
        default: ;
      endcase
    end
  end

  // The MAC flags a frame as either good or bad, never both
  a_good_bad_exclusive: assert property (
    @(posedge i_clk) disable iff (i_areset)
    !(i_rx_good && i_rx_bad)
  );

endmodule

`default_nettype wire

/* rtl/nts_dispatcher.sv */
`timescale 1ns/100ps
`default_nettype none

module nts_dispatcher #(
  parameter int ADDR_WIDTH = 8
) (
  input  wire                                       i_clk,
  input  wire                                       i_areset,

  // MAC receive
  input  wire [nts_dispatcher_pkg::KEEP_WIDTH-1:0]  i_rx_data_valid,
  input  wire [nts_dispatcher_pkg::DATA_WIDTH-1:0]  i_rx_data,
  input  wire                                       i_rx_bad_frame,
  input  wire                                       i_rx_good_frame,

  // Engine dispatch
  output wire                                       o_dispatch_packet_available,
  input  wire                                       i_dispatch_packet_read_discard,
  output wire [ADDR_WIDTH-1:0]                      o_dispatch_counter,
  output wire [nts_dispatcher_pkg::KEEP_WIDTH-1:0]  o_dispatch_data_valid,
  output wire                                       o_dispatch_fifo_empty,
  input  wire                                       i_dispatch_fifo_rd_start,
  output wire                                       o_dispatch_fifo_rd_valid,
  output wire [nts_dispatcher_pkg::DATA_WIDTH-1:0]  o_dispatch_fifo_rd_data,

  // Register bus, write data has no destination in this core
  input  wire                                       i_api_cs,
  input  wire                                       i_api_we,
  input  wire nts_dispatcher_pkg::api_addr_t        i_api_address,
  input  wire nts_dispatcher_pkg::api_word_t        i_api_write_data,
  output wire nts_dispatcher_pkg::api_word_t        o_api_read_data
);

  wire sof;
  wire dispatch_start;

  bank_if #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank_if0 ();
  bank_if #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank_if1 ();

  //--------------------------------------------------------------------------
  // Ping-pong banks
  //--------------------------------------------------------------------------

  frame_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank0 (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_rx_data (i_rx_data),
    .i_rx_keep (i_rx_data_valid),
    .i_rx_good (i_rx_good_frame),
    .i_rx_bad  (i_rx_bad_frame),
    .i_sof     (sof),
    .bank      (u_bank_if0.bank)
  );

  frame_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank1 (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_rx_data (i_rx_data),
    .i_rx_keep (i_rx_data_valid),
    .i_rx_good (i_rx_good_frame),
    .i_rx_bad  (i_rx_bad_frame),
    .i_sof     (sof),
    .bank      (u_bank_if1.bank)
  );

  bank_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arbiter (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .bank0                          (u_bank_if0.arbiter),
    .bank1                          (u_bank_if1.arbiter),
    .o_dispatch_packet_available    (o_dispatch_packet_available),
    .o_dispatch_counter             (o_dispatch_counter),
    .o_dispatch_data_valid          (o_dispatch_data_valid),
    .o_dispatch_fifo_empty          (o_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_start       (i_dispatch_fifo_rd_start),
    .o_dispatch_fifo_rd_valid       (o_dispatch_fifo_rd_valid),
    .o_dispatch_fifo_rd_data        (o_dispatch_fifo_rd_data),
    .i_dispatch_packet_read_discard (i_dispatch_packet_read_discard),
    .o_dispatch_start               (dispatch_start)
  );

  //--------------------------------------------------------------------------
  // Statistics and register port
  //--------------------------------------------------------------------------

  rx_stats u_stats (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_rx_keep        (i_rx_data_valid),
    .i_rx_good        (i_rx_good_frame),
    .i_rx_bad         (i_rx_bad_frame),
    .i_dispatch_start (dispatch_start),
    .o_sof            (sof),
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .o_api_read_data  (o_api_read_data)
  );

endmodule

`default_nettype wire

/* verification/tb_nts_dispatcher.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_nts_dispatcher;

  localparam int ADDR_WIDTH      = 4;
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int WAIT_LIMIT      = 200;

  typedef logic [ADDR_WIDTH-1:0] count_t;

  logic                           i_clk;
  logic                           i_areset;
  nts_dispatcher_pkg::keep_t      i_rx_data_valid;
  nts_dispatcher_pkg::data_word_t i_rx_data;
  logic                           i_rx_bad_frame;
  logic                           i_rx_good_frame;
  logic                           o_dispatch_packet_available;
  logic                           i_dispatch_packet_read_discard;
  count_t                         o_dispatch_counter;
  nts_dispatcher_pkg::keep_t      o_dispatch_data_valid;
  logic                           o_dispatch_fifo_empty;
  logic                           i_dispatch_fifo_rd_start;
  logic                           o_dispatch_fifo_rd_valid;
  nts_dispatcher_pkg::data_word_t o_dispatch_fifo_rd_data;
  logic                           i_api_cs;
  logic                           i_api_we;
  nts_dispatcher_pkg::api_addr_t  i_api_address;
  nts_dispatcher_pkg::api_word_t  i_api_write_data;
  nts_dispatcher_pkg::api_word_t  o_api_read_data;

  logic [15:0]                    lfsr_state;

  // Good frames waiting to be dispatched, oldest first
  nts_dispatcher_pkg::data_word_t exp_words [$];
  int                             exp_lens [$];
  nts_dispatcher_pkg::keep_t      exp_keeps [$];

  nts_dispatcher_pkg::counter_t   n_frames;
  nts_dispatcher_pkg::counter_t   n_good;
  nts_dispatcher_pkg::counter_t   n_bad;
  nts_dispatcher_pkg::counter_t   n_dispatched;

  nts_dispatcher #(.ADDR_WIDTH(ADDR_WIDTH)) u_dut (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .i_rx_data_valid                (i_rx_data_valid),
    .i_rx_data                      (i_rx_data),
    .i_rx_bad_frame                 (i_rx_bad_frame),
    .i_rx_good_frame                (i_rx_good_frame),
    .o_dispatch_packet_available    (o_dispatch_packet_available),
    .i_dispatch_packet_read_discard (i_dispatch_packet_read_discard),
    .o_dispatch_counter             (o_dispatch_counter),
    .o_dispatch_data_valid          (o_dispatch_data_valid),
    .o_dispatch_fifo_empty          (o_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_start       (i_dispatch_fifo_rd_start),
    .o_dispatch_fifo_rd_valid       (o_dispatch_fifo_rd_valid),
    .o_dispatch_fifo_rd_data        (o_dispatch_fifo_rd_data),
    .i_api_cs                       (i_api_cs),
    .i_api_we                       (i_api_we),
    .i_api_address                  (i_api_address),
    .i_api_write_data               (i_api_write_data),
    .o_api_read_data                (o_api_read_data)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end
  end

  initial begin
    #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    abort_run("Watchdog expired before the tests completed");
  end

  //--------------------------------------------------------------------------
  // Failure exit, LFSR and compare tasks
  //--------------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic nts_dispatcher_pkg::data_word_t random_word();
    nts_dispatcher_pkg::data_word_t w;
    w = '0;
    for (int i = 0; i < nts_dispatcher_pkg::DATA_WIDTH; i++) begin
      w = {w[nts_dispatcher_pkg::DATA_WIDTH-2:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic check_word(input nts_dispatcher_pkg::data_word_t got,
                            input nts_dispatcher_pkg::data_word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_keep(input nts_dispatcher_pkg::keep_t got,
                            input nts_dispatcher_pkg::keep_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_api(input nts_dispatcher_pkg::api_word_t got,
                           input nts_dispatcher_pkg::api_word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //--------------------------------------------------------------------------
  // Drive tasks
  //--------------------------------------------------------------------------

  task automatic drive_beat(input nts_dispatcher_pkg::data_word_t data,
                            input nts_dispatcher_pkg::keep_t keep, input logic good,
                            input logic bad);
    @(posedge i_clk);
    #1;
    i_rx_data       = data;
    i_rx_data_valid = keep;
    i_rx_good_frame = good;
    i_rx_bad_frame  = bad;
  endtask

  // Idle beat first so the full first beat is seen as a start of frame
  task automatic send_frame(input int beats, input nts_dispatcher_pkg::keep_t last_keep,
                            input logic good);
    nts_dispatcher_pkg::data_word_t word;
    nts_dispatcher_pkg::keep_t      keep;
    logic                           last;
    drive_beat('0, '0, 1'b0, 1'b0);
    for (int i = 0; i < beats; i++) begin
      last = (i == beats - 1);
      keep = last ? last_keep : 8'hFF;
      word = random_word();
      drive_beat(word, keep, last && good, last && !good);
      if (good) begin
        exp_words.push_back(word);
      end
    end
    drive_beat('0, '0, 1'b0, 1'b0);
    n_frames = n_frames + 64'd1;
    if (good) begin
      exp_lens.push_back(beats);
      exp_keeps.push_back(last_keep);
      n_good = n_good + 64'd1;
    end else begin
      n_bad = n_bad + 64'd1;
    end
  endtask

  task automatic read_frame();
    int                        len;
    int                        n;
    int                        waited;
    nts_dispatcher_pkg::keep_t keep;
    len    = exp_lens.pop_front();
    keep   = exp_keeps.pop_front();
    waited = 0;
    @(negedge i_clk);
    while (!o_dispatch_packet_available) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout while waiting for a frame to be offered");
      end
      @(negedge i_clk);
    end
    check_count(o_dispatch_counter, count_t'(len - 1), "dispatch counter");
    check_keep(o_dispatch_data_valid, keep, "dispatch data valid");
    check_flag(o_dispatch_fifo_empty, 1'b0, "fifo empty during offer");
    @(posedge i_clk);
    #1;
    i_dispatch_fifo_rd_start = 1'b1;
    @(posedge i_clk);
    #1;
    i_dispatch_fifo_rd_start = 1'b0;
    n_dispatched = n_dispatched + 64'd1;
    waited = 0;
    @(negedge i_clk);
    while (!o_dispatch_fifo_rd_valid) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout while waiting for the read-out stream");
      end
      @(negedge i_clk);
    end
    n = 0;
    while (o_dispatch_fifo_rd_valid) begin
      if (n >= len) begin
        abort_run("Read valid stayed high past the end of the frame");
      end
      check_word(o_dispatch_fifo_rd_data, exp_words.pop_front(), "read data");
      n++;
      @(negedge i_clk);
    end
    if (n != len) begin
      abort_run($sformatf("Mismatch at %0t: %0d words read, expected %0d", $time, n, len));
    end
    check_flag(o_dispatch_fifo_empty, 1'b1, "fifo empty after read");
    check_flag(o_dispatch_packet_available, 1'b0, "packet available before discard");
    @(posedge i_clk);
    #1;
    i_dispatch_packet_read_discard = 1'b1;
    @(posedge i_clk);
    #1;
    i_dispatch_packet_read_discard = 1'b0;
  endtask

  task automatic api_read(input nts_dispatcher_pkg::api_addr_t addr,
                          output nts_dispatcher_pkg::api_word_t data);
    @(posedge i_clk);
    #1;
    i_api_cs      = 1'b1;
    i_api_we      = 1'b0;
    i_api_address = addr;
    @(negedge i_clk);
    data = o_api_read_data;
    @(posedge i_clk);
    #1;
    i_api_cs = 1'b0;
  endtask

  task automatic api_write(input nts_dispatcher_pkg::api_addr_t addr,
                           input nts_dispatcher_pkg::api_word_t data);
    @(posedge i_clk);
    #1;
    i_api_cs         = 1'b1;
    i_api_we         = 1'b1;
    i_api_address    = addr;
    i_api_write_data = data;
    @(negedge i_clk);
    check_api(o_api_read_data, '0, "read data during a write");
    @(posedge i_clk);
    #1;
    i_api_cs = 1'b0;
    i_api_we = 1'b0;
  endtask

  // MSB read first since it loads the LSB snapshot
  task automatic check_counter(input nts_dispatcher_pkg::api_addr_t msb_addr,
                               input nts_dispatcher_pkg::counter_t exp, input string name);
    nts_dispatcher_pkg::api_word_t data;
    api_read(msb_addr, data);
    check_api(data, exp[63:32], {name, " MSB"});
    api_read(msb_addr + 12'd1, data);
    check_api(data, exp[31:0], {name, " LSB"});
  endtask

  task automatic check_all_counters();
    check_counter(nts_dispatcher_pkg::ADDR_FRAMES_MSB, n_frames, "frames counter");
    check_counter(nts_dispatcher_pkg::ADDR_GOOD_MSB, n_good, "good counter");
    check_counter(nts_dispatcher_pkg::ADDR_BAD_MSB, n_bad, "bad counter");
    check_counter(nts_dispatcher_pkg::ADDR_DISPATCHED_MSB, n_dispatched, "dispatched counter");
  endtask

  //--------------------------------------------------------------------------
  // Directed tests
  //--------------------------------------------------------------------------

  task automatic test_reset_state();
    nts_dispatcher_pkg::api_word_t data;
    @(negedge i_clk);
    check_flag(o_dispatch_packet_available, 1'b0, "packet available after reset");
    check_flag(o_dispatch_fifo_empty, 1'b1, "fifo empty after reset");
    check_flag(o_dispatch_fifo_rd_valid, 1'b0, "read valid after reset");
    check_api(o_api_read_data, '0, "read data while not selected");
    for (int i = 0; i < 8; i++) begin
      api_read(nts_dispatcher_pkg::api_addr_t'(nts_dispatcher_pkg::ADDR_FRAMES_MSB + i), data);
      check_api(data, '0, $sformatf("counter register %0d after reset", i));
    end
  endtask

  task automatic test_single_frame();
    send_frame(5, 8'h0F, 1'b1);
    read_frame();
  endtask

  // Second frame waits in its bank until the first is discarded
  task automatic test_back_to_back();
    send_frame(3, 8'hFF, 1'b1);
    send_frame(7, 8'h3F, 1'b1);
    read_frame();
    read_frame();
  endtask

  task automatic test_bad_frame();
    send_frame(4, 8'h07, 1'b0);
    repeat (20) begin
      @(negedge i_clk);
      check_flag(o_dispatch_packet_available, 1'b0, "packet available after bad frame");
    end
    send_frame(6, 8'h01, 1'b1);
    read_frame();
  endtask

  task automatic test_counters();
    nts_dispatcher_pkg::data_word_t w;
    check_all_counters();
    w = random_word();
    api_write(nts_dispatcher_pkg::ADDR_FRAMES_MSB, w[63:32]);
    api_write(nts_dispatcher_pkg::ADDR_DISPATCHED_LSB, w[31:0]);
    check_all_counters();
  endtask

  initial begin
    lfsr_state                     = 16'd62;
    n_frames                       = '0;
    n_good                         = '0;
    n_bad                          = '0;
    n_dispatched                   = '0;
    i_areset                       = 1'b1;
    i_rx_data_valid                = '0;
    i_rx_data                      = '0;
    i_rx_bad_frame                 = 1'b0;
    i_rx_good_frame                = 1'b0;
    i_dispatch_packet_read_discard = 1'b0;
    i_dispatch_fifo_rd_start       = 1'b0;
    i_api_cs                       = 1'b0;
    i_api_we                       = 1'b0;
    i_api_address                  = '0;
    i_api_write_data               = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_areset = 1'b0;

    test_reset_state();
    test_single_frame();
    test_back_to_back();
    test_bad_frame();
    test_counters();

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/nts_dispatcher_pkg.sv
rtl/bank_if.sv
rtl/frame_bank.sv
rtl/bank_arbiter.sv
rtl/rx_stats.sv
rtl/nts_dispatcher.sv
verification/tb_nts_dispatcher.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

TOP=tb_nts_dispatcher
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module "$TOP" -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0
